/* sources.f */
design/rv_isa_pkg.sv
design/dispatch_pkg.sv
design/instr_decoder.sv
design/station_queue.sv
design/dispatch_router.sv
design/decode_dispatch_top.sv
tests/decode_dispatch_sva.sv
tests/decode_dispatch_tb.sv

/* tests/decode_dispatch_tb.sv */
// Random-instruction testbench for the decode and dispatch front end with a reference model
`timescale 1ns/1ps

module decode_dispatch_tb;
  import rv_isa_pkg::*;
  import dispatch_pkg::*;

  localparam int clk_period    = 100;
  localparam int n_field       = 6;  // Words per opcode
  localparam int n_route       = 40;
  localparam int n_illegal     = 13;
  localparam int n_over        = 5;
  localparam int n_rand        = 400;
  localparam int drain_limit   = 40;
  localparam int total_strobes = 11 * n_field + n_route + 3 + n_illegal + n_over + 3 + n_rand;
  localparam int watchdog_cycles = total_strobes + 6 * (drain_limit + 24);

  localparam logic [6:0] opcodes [11] = '{op_load, op_store, op_branch, op_jal, op_jalr,
                                          op_imm, op_reg, op_lui, op_auipc, op_misc_mem,
                                          op_system};

  typedef struct packed {
    pid_e        pid;
    width_e      width;
    station_e    station;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        writes;
    logic        jumps;
    logic        uses_imm;
  } dec_t;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic        alu_issue;
  logic        ls_issue;
  logic        br_issue;
  alu_entry_t  alu_head;
  logic        alu_valid;
  logic        alu_overflow;
  ls_entry_t   ls_head;
  logic        ls_valid;
  logic        ls_overflow;
  br_entry_t   br_head;
  logic        br_valid;
  logic        br_overflow;
  logic        illegal;

  integer seed;
  int     pop_mode;  // 0 hold, 1 random, 2 always
  int     n_checks;
  int     n_errors;
  int     n_tests;
  int     test_checks;
  int     test_errors;

  // Model pipeline and queues
  logic       s1_v;
  logic       s2_v;
  dec_t       s1_d;
  dec_t       s2_d;
  alu_entry_t alu_model [$];
  ls_entry_t  ls_model [$];
  br_entry_t  br_model [$];
  logic       m_alu_ovf;
  logic       m_ls_ovf;
  logic       m_br_ovf;

  decode_dispatch_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .alu_issue    (alu_issue),
    .ls_issue     (ls_issue),
    .br_issue     (br_issue),
    .alu_head     (alu_head),
    .alu_valid    (alu_valid),
    .alu_overflow (alu_overflow),
    .ls_head      (ls_head),
    .ls_valid     (ls_valid),
    .ls_overflow  (ls_overflow),
    .br_head      (br_head),
    .br_valid     (br_valid),
    .br_overflow  (br_overflow),
    .illegal      (illegal)
  );

  function automatic dec_t ref_decode(input logic [31:0] w);
    dec_t        d;
    logic [2:0]  f3;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] u_imm;
    logic [31:0] j_imm;
    f3    = w[14:12];
    i_imm = {{20{w[31]}}, w[31:20]};
    s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
    b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    u_imm = {w[31:12], 12'd0};
    j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    d       = '0;
    d.width = width_none;
    if (w != 32'd0) begin
      case (w[6:2])
        op_lui[6:2]:      d.pid = pid_lui;
        op_auipc[6:2]:    d.pid = pid_auipc;
        op_jal[6:2]:      d.pid = pid_jal;
        op_jalr[6:2]:     d.pid = (f3 == 3'd0) ? pid_jalr : pid_unknown;
        op_misc_mem[6:2]: d.pid = (f3 == 3'd0) ? pid_addi : pid_unknown;
        op_system[6:2]:   if (f3 == 3'd0) d.pid = w[20] ? pid_ebreak : pid_ecall;
        op_load[6:2]:
          case (f3)
            3'd0:    d.pid = pid_lb;
            3'd1:    d.pid = pid_lh;
            3'd2:    d.pid = pid_lw;
            3'd4:    d.pid = pid_lbu;
            3'd5:    d.pid = pid_lhu;
            default: d.pid = pid_unknown;
          endcase
        op_store[6:2]:
          case (f3)
            3'd0:    d.pid = pid_sb;
            3'd1:    d.pid = pid_sh;
            3'd2:    d.pid = pid_sw;
            default: d.pid = pid_unknown;
          endcase
        op_branch[6:2]:
          case (f3)
            3'd0:    d.pid = pid_beq;
            3'd1:    d.pid = pid_bne;
            3'd4:    d.pid = pid_blt;
            3'd5:    d.pid = pid_bge;
            3'd6:    d.pid = pid_bltu;
            3'd7:    d.pid = pid_bgeu;
            default: d.pid = pid_unknown;
          endcase
        op_imm[6:2]:
          case (f3)
            3'd0:    d.pid = pid_addi;
            3'd1:    d.pid = pid_slli;
            3'd2:    d.pid = pid_slti;
            3'd3:    d.pid = pid_sltiu;
            3'd4:    d.pid = pid_xori;
            3'd5:    d.pid = w[30] ? pid_srai : pid_srli;
            3'd6:    d.pid = pid_ori;
            default: d.pid = pid_andi;
          endcase
        op_reg[6:2]:
          case (f3)
            3'd0:    d.pid = w[30] ? pid_sub : pid_add;
            3'd1:    d.pid = pid_sll;
            3'd2:    d.pid = pid_slt;
            3'd3:    d.pid = pid_sltu;
            3'd4:    d.pid = pid_xor;
            3'd5:    d.pid = w[30] ? pid_sra : pid_srl;
            3'd6:    d.pid = pid_or;
            default: d.pid = pid_and;
          endcase
        default: d.pid = pid_unknown;
      endcase
    end
    if (d.pid != pid_unknown) begin
      case (w[6:2])
        op_load[6:2], op_store[6:2]: begin
          d.station  = station_ls;
          d.width    = width_e'(f3[1:0]);  // Access size from funct3
          d.rs1      = w[19:15];
          d.uses_imm = 1'b1;
          if (w[5]) begin
            d.rs2 = w[24:20];
            d.imm = s_imm;
          end else begin
            d.rd     = w[11:7];
            d.imm    = i_imm;
            d.writes = 1'b1;
          end
        end
        op_branch[6:2]: begin
          d.station  = station_br;
          d.rs1      = w[19:15];
          d.rs2      = w[24:20];
          d.imm      = b_imm;
          d.jumps    = 1'b1;
          d.uses_imm = 1'b1;
        end
        op_jal[6:2], op_jalr[6:2]: begin
          d.station  = station_br;
          d.rd       = w[11:7];
          d.writes   = 1'b1;
          d.jumps    = 1'b1;
          d.uses_imm = 1'b1;
          if (w[3]) begin
            d.imm = j_imm;
          end else begin
            d.rs1 = w[19:15];
            d.imm = i_imm;
          end
        end
        op_imm[6:2]: begin
          d.station  = station_alu;
          d.rd       = w[11:7];
          d.rs1      = w[19:15];
          d.imm      = (f3 == 3'd1 || f3 == 3'd5) ? {27'd0, w[24:20]} : i_imm;
          d.writes   = 1'b1;
          d.uses_imm = 1'b1;
        end
        op_reg[6:2]: begin
          d.station = station_alu;
          d.rd      = w[11:7];
          d.rs1     = w[19:15];
          d.rs2     = w[24:20];
          d.writes  = 1'b1;
        end
        op_lui[6:2], op_auipc[6:2]: begin
          d.station  = station_alu;
          d.rd       = w[11:7];
          d.imm      = u_imm;
          d.writes   = 1'b1;
          d.uses_imm = 1'b1;
        end
        op_misc_mem[6:2]: d.station = station_alu;
        default:          d.station = station_br;  // ECALL, EBREAK
      endcase
    end
    return d;
  endfunction

  function automatic alu_entry_t to_alu(input dec_t d);
    return '{pid: d.pid, rd: d.rd, rs1: d.rs1, rs2: d.rs2, imm: d.imm,
             uses_imm: d.uses_imm, writes: d.writes};
  endfunction

  function automatic ls_entry_t to_ls(input dec_t d);
    return '{pid: d.pid, width: d.width, rd: d.rd, rs1: d.rs1, rs2: d.rs2,
             imm: d.imm, writes: d.writes};
  endfunction

  function automatic br_entry_t to_br(input dec_t d);
    return '{pid: d.pid, rd: d.rd, rs1: d.rs1, rs2: d.rs2, imm: d.imm,
             writes: d.writes, jumps: d.jumps};
  endfunction

  function automatic logic is_idle();
    return !s1_v && !s2_v && alu_model.size() == 0 && ls_model.size() == 0 &&
           br_model.size() == 0 && !alu_valid && !ls_valid && !br_valid;
  endfunction

  task automatic check_alu(input alu_entry_t got, input alu_entry_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ls(input ls_entry_t got, input ls_entry_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_br(input br_entry_t got, input br_entry_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // One clock of stimulus
  task automatic tick(input logic v, input logic [31:0] w);
    @(posedge clk);
    instr_valid <= v;
    instr       <= w;
    case (pop_mode)
      0: begin
        alu_issue <= 1'b0;
        ls_issue  <= 1'b0;
        br_issue  <= 1'b0;
      end
      1: begin
        alu_issue <= ($random(seed) & 3) != 0;
        ls_issue  <= ($random(seed) & 3) != 0;
        br_issue  <= ($random(seed) & 3) != 0;
      end
      default: begin
        alu_issue <= 1'b1;
        ls_issue  <= 1'b1;
        br_issue  <= 1'b1;
      end
    endcase
  endtask

  task automatic random_word(input int op_idx, input logic allow_junk,
                             output logic [31:0] w);
    int r;
    int idx;
    w   = $random(seed);
    r   = $random(seed);
    idx = (op_idx < 0) ? int'(r[15:8]) % 11 : op_idx;
    if (!(allow_junk && r[2:0] == 3'd0)) w[6:0] = opcodes[idx];  // Else fully random
  endtask

  task automatic send_bad(input logic [6:0] opc, input logic [2:0] f3);
    logic [31:0] w;
    w        = $random(seed);
    w[14:12] = f3;
    w[6:0]   = opc;
    tick(1'b1, w);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset       <= 1'b1;
    instr_valid <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    int cycles;
    cycles   = 0;
    pop_mode = 2;
    do begin
      tick(1'b0, 32'h0);
      @(negedge clk);
      cycles++;
    end while (!is_idle() && cycles < drain_limit);
    if (!is_idle()) begin
      n_errors++;
      $display("test %s: queues did not drain within %0d cycles", name, drain_limit);
    end
    @(posedge clk);
    $display("test %s: %0d checks, %0d errors", name, n_checks - test_checks,
             n_errors - test_errors);
    n_tests++;
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Queue stage acts on the push decided one edge earlier
  always @(posedge clk) begin
    if (reset) begin
      s1_v = 1'b0;
      s2_v = 1'b0;
      alu_model.delete();
      ls_model.delete();
      br_model.delete();
      m_alu_ovf = 1'b0;
      m_ls_ovf  = 1'b0;
      m_br_ovf  = 1'b0;
    end else begin
      if (alu_issue && alu_model.size() != 0) alu_model.delete(0);
      if (ls_issue && ls_model.size() != 0) ls_model.delete(0);
      if (br_issue && br_model.size() != 0) br_model.delete(0);
      if (s2_v && s2_d.station == station_alu) begin
        if (alu_model.size() < queue_depth) alu_model.push_back(to_alu(s2_d));
        else m_alu_ovf = 1'b1;
      end
      if (s2_v && s2_d.station == station_ls) begin
        if (ls_model.size() < queue_depth) ls_model.push_back(to_ls(s2_d));
        else m_ls_ovf = 1'b1;
      end
      if (s2_v && s2_d.station == station_br) begin
        if (br_model.size() < queue_depth) br_model.push_back(to_br(s2_d));
        else m_br_ovf = 1'b1;
      end
      s2_v = s1_v;
      s2_d = s1_d;
      s1_v = instr_valid;
      s1_d = ref_decode(instr);
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      check_flag(illegal, s2_v && s2_d.pid == pid_unknown, "illegal pulse");
      check_flag(alu_valid, alu_model.size() != 0, "alu valid");
      check_flag(ls_valid, ls_model.size() != 0, "ls valid");
      check_flag(br_valid, br_model.size() != 0, "br valid");
      check_flag(alu_overflow, m_alu_ovf, "alu overflow");
      check_flag(ls_overflow, m_ls_ovf, "ls overflow");
      check_flag(br_overflow, m_br_ovf, "br overflow");
      if (alu_valid && alu_model.size() != 0) check_alu(alu_head, alu_model[0], "alu head");
      if (ls_valid && ls_model.size() != 0) check_ls(ls_head, ls_model[0], "ls head");
      if (br_valid && br_model.size() != 0) check_br(br_head, br_model[0], "br head");
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] w;
    seed        = 32'h7e;
    pop_mode    = 0;
    n_checks    = 0;
    n_errors    = 0;
    n_tests     = 0;
    test_checks = 0;
    test_errors = 0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'h0;
    alu_issue   = 1'b0;
    ls_issue    = 1'b0;
    br_issue    = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    pop_mode = 2;
    for (int op = 0; op < 11; op++) begin
      for (int k = 0; k < n_field; k++) begin
        random_word(op, 1'b0, w);
        tick(1'b1, w);
      end
    end
    finish_test("fields");

    for (int k = 0; k < n_route; k++) begin
      random_word(-1, 1'b0, w);
      tick(1'b1, w);
    end
    tick(1'b1, 32'h0000_0073);  // ECALL
    tick(1'b1, 32'h0010_0073);  // EBREAK
    tick(1'b1, 32'h0ff0_000f);  // FENCE
    finish_test("routing");

    tick(1'b1, 32'h0);
    send_bad(op_load, 3'd3);
    send_bad(op_load, 3'd6);
    send_bad(op_load, 3'd7);
    send_bad(op_store, 3'd3);
    send_bad(op_store, 3'd5);
    send_bad(op_store, 3'd7);
    send_bad(op_branch, 3'd2);
    send_bad(op_branch, 3'd3);
    send_bad(op_jalr, 3'd4);
    send_bad(op_misc_mem, 3'd1);
    send_bad(op_system, 3'd2);
    send_bad(7'b0101111, 3'd0);  // No such major opcode
    finish_test("illegal");

    // ALU queue never popped
    pop_mode = 0;
    for (int k = 0; k < n_over; k++) begin
      random_word(5, 1'b0, w);
      tick(1'b1, w);
    end
    repeat (4) tick(1'b0, 32'h0);
    @(negedge clk);
    check_flag(alu_overflow, 1'b1, "alu overflow after five pushes");
    check_flag(ls_overflow, 1'b0, "ls overflow during alu overflow");
    check_flag(br_overflow, 1'b0, "br overflow during alu overflow");
    check_flag(ls_valid, 1'b0, "ls valid during alu overflow");
    check_flag(br_valid, 1'b0, "br valid during alu overflow");
    finish_test("overflow");

    // One entry left in each queue across the reset
    pop_mode = 0;
    tick(1'b1, 32'h0000_2083);  // LW x1, 0(x0)
    tick(1'b1, 32'h0000_0063);  // BEQ x0, x0, 0
    tick(1'b1, 32'h0010_0093);  // ADDI x1, x0, 1
    repeat (3) tick(1'b0, 32'h0);
    @(negedge clk);
    check_flag(alu_valid, 1'b1, "alu valid before reset");
    check_flag(ls_valid, 1'b1, "ls valid before reset");
    check_flag(br_valid, 1'b1, "br valid before reset");
    apply_reset();
    check_flag(alu_overflow, 1'b0, "alu overflow after reset");
    check_flag(ls_overflow, 1'b0, "ls overflow after reset");
    check_flag(br_overflow, 1'b0, "br overflow after reset");
    check_flag(alu_valid, 1'b0, "alu valid after reset");
    check_flag(ls_valid, 1'b0, "ls valid after reset");
    check_flag(br_valid, 1'b0, "br valid after reset");
    check_flag(illegal, 1'b0, "illegal after reset");
    finish_test("reset");

    pop_mode = 1;
    for (int k = 0; k < n_rand; k++) begin
      random_word(-1, 1'b1, w);
      tick(1'b1, w);
    end
    finish_test("throughput");

    @(posedge clk);
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* tests/decode_dispatch_sva.sv */
// Assertions on dispatch strobes from the router and on station queue flags
`timescale 1ns/1ps

module decode_dispatch_sva (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic alu_push,
  input logic ls_push,
  input logic br_push,
  input logic illegal,
  input logic push,
  input logic valid,
  input logic overflow
);

  // One outcome per decoded word
  single_dispatch: assert property (@(posedge clk) disable iff (reset)
    $onehot0({alu_push, ls_push, br_push, illegal}))
    else $error("more than one push or illegal pulse in one cycle");

  // Strobe, decode register, then push
  push_after_strobe: assert property (@(posedge clk) disable iff (reset)
    (alu_push || ls_push || br_push || illegal) |-> $past(instr_valid, 2))
    else $error("push or illegal pulse without a strobe two cycles earlier");

  valid_needs_push: assert property (@(posedge clk) disable iff (reset)
    $rose(valid) |-> $past(push))
    else $error("queue valid rose without a push");

  overflow_sticky: assert property (@(posedge clk) disable iff (reset)
    $fell(overflow) |-> $past(reset))
    else $error("overflow fell outside reset");

endmodule

bind dispatch_router decode_dispatch_sva router_sva_i (
  .clk         (clk),
  .reset       (reset),
  .instr_valid (instr_valid),
  .alu_push    (alu_push),
  .ls_push     (ls_push),
  .br_push     (br_push),
  .illegal     (illegal),
  .push        (1'b0),
  .valid       (1'b0),
  .overflow    (1'b0)
);

bind station_queue decode_dispatch_sva queue_sva_i (
  .clk         (clk),
  .reset       (reset),
  .instr_valid (1'b0),
  .alu_push    (1'b0),
  .ls_push     (1'b0),
  .br_push     (1'b0),
  .illegal     (1'b0),
  .push        (push),
  .valid       (valid),
  .overflow    (overflow)
);

/* design/decode_dispatch_top.sv */
// Decode and dispatch front end feeding the ALU, load/store and branch station queues
`timescale 1ns/1ps

module decode_dispatch_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     instr_valid,
  input  logic [31:0]              instr,
  input  logic                     alu_issue,
  input  logic                     ls_issue,
  input  logic                     br_issue,
  output dispatch_pkg::alu_entry_t alu_head,
  output logic                     alu_valid,
  output logic                     alu_overflow,
  output dispatch_pkg::ls_entry_t  ls_head,
  output logic                     ls_valid,
  output logic                     ls_overflow,
  output dispatch_pkg::br_entry_t  br_head,
  output logic                     br_valid,
  output logic                     br_overflow,
  output logic                     illegal
);

  logic                     alu_push;
  logic                     ls_push;
  logic                     br_push;
  dispatch_pkg::alu_entry_t alu_entry;
  dispatch_pkg::ls_entry_t  ls_entry;
  dispatch_pkg::br_entry_t  br_entry;

  dispatch_router router_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .alu_push    (alu_push),
    .alu_entry   (alu_entry),
    .ls_push     (ls_push),
    .ls_entry    (ls_entry),
    .br_push     (br_push),
    .br_entry    (br_entry),
    .illegal     (illegal)
  );

  station_queue #(.entry_t(dispatch_pkg::alu_entry_t)) alu_q_i (
    .clk        (clk),
    .reset      (reset),
    .push       (alu_push),
    .push_entry (alu_entry),
    .issue      (alu_issue),
    .head       (alu_head),
    .valid      (alu_valid),
    .overflow   (alu_overflow)
  );

  station_queue #(.entry_t(dispatch_pkg::ls_entry_t)) ls_q_i (
    .clk        (clk),
    .reset      (reset),
    .push       (ls_push),
    .push_entry (ls_entry),
    .issue      (ls_issue),
    .head       (ls_head),
    .valid      (ls_valid),
    .overflow   (ls_overflow)
  );

  station_queue #(.entry_t(dispatch_pkg::br_entry_t)) br_q_i (
    .clk        (clk),
    .reset      (reset),
    .push       (br_push),
    .push_entry (br_entry),
    .issue      (br_issue),
    .head       (br_head),
    .valid      (br_valid),
    .overflow   (br_overflow)
  );

endmodule

/* design/dispatch_router.sv */
// Decode stage register and station routing for each strobed instruction word
`timescale 1ns/1ps

module dispatch_router (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     instr_valid,
  input  logic [31:0]              instr,
  output logic                     alu_push,
  output dispatch_pkg::alu_entry_t alu_entry,
  output logic                     ls_push,
  output dispatch_pkg::ls_entry_t  ls_entry,
  output logic                     br_push,
  output dispatch_pkg::br_entry_t  br_entry,
  output logic                     illegal
);
  import rv_isa_pkg::*;
  import dispatch_pkg::*;

  pid_e        d_pid;
  width_e      d_width;
  station_e    d_station;
  logic [4:0]  d_rd;
  logic [4:0]  d_rs1;
  logic [4:0]  d_rs2;
  logic [31:0] d_imm;
  logic        d_writes;
  logic        d_jumps;
  logic        d_uses_imm;

  logic        q_valid;
  pid_e        q_pid;
  width_e      q_width;
  station_e    q_station;
  logic [4:0]  q_rd;
  logic [4:0]  q_rs1;
  logic [4:0]  q_rs2;
  logic [31:0] q_imm;
  logic        q_writes;
  logic        q_jumps;
  logic        q_uses_imm;

  instr_decoder decoder_i (
    .instr    (instr),
    .pid      (d_pid),
    .width    (d_width),
    .station  (d_station),
    .rd       (d_rd),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .imm      (d_imm),
    .writes   (d_writes),
    .jumps    (d_jumps),
    .uses_imm (d_uses_imm)
  );

  always_ff @(posedge clk) begin
    if (reset) q_valid <= 1'b0;
    else q_valid <= instr_valid;
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      q_pid      <= d_pid;
      q_width    <= d_width;
      q_station  <= d_station;
      q_rd       <= d_rd;
      q_rs1      <= d_rs1;
      q_rs2      <= d_rs2;
      q_imm      <= d_imm;
      q_writes   <= d_writes;
      q_jumps    <= d_jumps;
      q_uses_imm <= d_uses_imm;
    end
  end

  // Unknown ops carry station_none, so they never push
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_push <= 1'b0;
      ls_push  <= 1'b0;
      br_push  <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      alu_push <= q_valid && (q_station == station_alu);
      ls_push  <= q_valid && (q_station == station_ls);
      br_push  <= q_valid && (q_station == station_br);
      illegal  <= q_valid && (q_pid == pid_unknown);
    end
  end

  always_ff @(posedge clk) begin
    if (q_valid) begin
      alu_entry <= '{pid: q_pid, rd: q_rd, rs1: q_rs1, rs2: q_rs2, imm: q_imm,
                     uses_imm: q_uses_imm, writes: q_writes};
      ls_entry  <= '{pid: q_pid, width: q_width, rd: q_rd, rs1: q_rs1, rs2: q_rs2,
                     imm: q_imm, writes: q_writes};
      br_entry  <= '{pid: q_pid, rd: q_rd, rs1: q_rs1, rs2: q_rs2, imm: q_imm,
                     writes: q_writes, jumps: q_jumps};
    end
  end

endmodule

/* design/station_queue.sv */
// Circular FIFO holding decoded entries in front of one reservation station
`timescale 1ns/1ps

module station_queue #(
  parameter type entry_t = logic
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   push,
  input  entry_t push_entry,
  input  logic   issue,
  output entry_t head,
  output logic   valid,
  output logic   overflow
);
  import dispatch_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  entry_t           mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    next_ptr = (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign valid   = (count != '0);
  assign full    = (count == cnt_w'(queue_depth));
  assign do_pop  = issue && valid;  // Pop on empty is ignored
  assign do_push = push && (!full || do_pop);
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_entry;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      if (push && !do_push) overflow <= 1'b1;  // Sticky until reset
    end
  end

endmodule

/* design/instr_decoder.sv */
// Combinational RV32I decoder giving operation id, fields, flags and target station
`timescale 1ns/1ps

module instr_decoder (
  input  logic [31:0]            instr,
  output rv_isa_pkg::pid_e       pid,
  output rv_isa_pkg::width_e     width,
  output dispatch_pkg::station_e station,
  output logic [4:0]             rd,
  output logic [4:0]             rs1,
  output logic [4:0]             rs2,
  output logic [31:0]            imm,
  output logic                   writes,
  output logic                   jumps,
  output logic                   uses_imm
);
  import rv_isa_pkg::*;
  import dispatch_pkg::*;

  logic [4:0]  opcode;
  logic [2:0]  funct3;
  logic        funct7_5;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm_sh;

  assign opcode   = instr[6:2];
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u  = {instr[31:12], 12'h000};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_sh = {27'd0, instr[24:20]};  // Shift amount

  always_comb begin
    pid = pid_unknown;
    if (instr != 32'h0000_0000) begin
      case (opcode)
        op_load[6:2]:
          case (funct3)
            3'b000:  pid = pid_lb;
            3'b001:  pid = pid_lh;
            3'b010:  pid = pid_lw;
            3'b100:  pid = pid_lbu;
            3'b101:  pid = pid_lhu;
            default: pid = pid_unknown;
          endcase
        op_store[6:2]:
          case (funct3)
            3'b000:  pid = pid_sb;
            3'b001:  pid = pid_sh;
            3'b010:  pid = pid_sw;
            default: pid = pid_unknown;
          endcase
        op_branch[6:2]:
          case (funct3)
            3'b000:  pid = pid_beq;
            3'b001:  pid = pid_bne;
            3'b100:  pid = pid_blt;
            3'b101:  pid = pid_bge;
            3'b110:  pid = pid_bltu;
            3'b111:  pid = pid_bgeu;
            default: pid = pid_unknown;
          endcase
        op_imm[6:2]:
          case (funct3)
            3'b000:  pid = pid_addi;
            3'b001:  pid = pid_slli;
            3'b010:  pid = pid_slti;
            3'b011:  pid = pid_sltiu;
            3'b100:  pid = pid_xori;
            3'b101:  pid = funct7_5 ? pid_srai : pid_srli;
            3'b110:  pid = pid_ori;
            default: pid = pid_andi;
          endcase
        op_reg[6:2]:
          case (funct3)
            3'b000:  pid = funct7_5 ? pid_sub : pid_add;
            3'b001:  pid = pid_sll;
            3'b010:  pid = pid_slt;
            3'b011:  pid = pid_sltu;
            3'b100:  pid = pid_xor;
            3'b101:  pid = funct7_5 ? pid_sra : pid_srl;
            3'b110:  pid = pid_or;
            default: pid = pid_and;
          endcase
        op_jal[6:2]:      pid = pid_jal;
        op_jalr[6:2]:     pid = (funct3 == 3'b000) ? pid_jalr : pid_unknown;
        op_lui[6:2]:      pid = pid_lui;
        op_auipc[6:2]:    pid = pid_auipc;
        op_misc_mem[6:2]: pid = (funct3 == 3'b000) ? pid_addi : pid_unknown;  // FENCE as nop
        op_system[6:2]: begin
          if (funct3 == 3'b000) pid = instr[20] ? pid_ebreak : pid_ecall;
        end
        default:          pid = pid_unknown;
      endcase
    end
  end

  always_comb begin
    station  = station_none;
    rd       = 5'd0;
    rs1      = 5'd0;
    rs2      = 5'd0;
    imm      = 32'd0;
    writes   = 1'b0;
    jumps    = 1'b0;
    uses_imm = 1'b0;
    if (pid != pid_unknown) begin
      case (opcode)
        op_load[6:2]: begin
          station  = station_ls;
          rd       = instr[11:7];
          rs1      = instr[19:15];
          imm      = imm_i;
          writes   = 1'b1;
          uses_imm = 1'b1;
        end
        op_store[6:2]: begin
          station  = station_ls;
          rs1      = instr[19:15];
          rs2      = instr[24:20];
          imm      = imm_s;
          uses_imm = 1'b1;
        end
        op_branch[6:2]: begin
          station  = station_br;
          rs1      = instr[19:15];
          rs2      = instr[24:20];
          imm      = imm_b;
          jumps    = 1'b1;
          uses_imm = 1'b1;
        end
        op_jal[6:2], op_jalr[6:2]: begin
          station  = station_br;
          rd       = instr[11:7];
          rs1      = opcode[1] ? 5'd0 : instr[19:15];  // JAL has no rs1
          imm      = opcode[1] ? imm_j : imm_i;
          writes   = 1'b1;
          jumps    = 1'b1;
          uses_imm = 1'b1;
        end
        op_imm[6:2]: begin
          station  = station_alu;
          rd       = instr[11:7];
          rs1      = instr[19:15];
          imm      = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
          writes   = 1'b1;
          uses_imm = 1'b1;
        end
        op_reg[6:2]: begin
          station  = station_alu;
          rd       = instr[11:7];
          rs1      = instr[19:15];
          rs2      = instr[24:20];
          writes   = 1'b1;
        end
        op_lui[6:2], op_auipc[6:2]: begin
          station  = station_alu;
          rd       = instr[11:7];
          imm      = imm_u;
          writes   = 1'b1;
          uses_imm = 1'b1;
        end
        op_misc_mem[6:2]: station = station_alu;  // Fields stay zero
        op_system[6:2]:   station = station_br;
        default:          station = station_none;
      endcase
    end
  end

  always_comb begin
    case (pid)
      pid_lb, pid_lbu, pid_sb: width = width_byte;
      pid_lh, pid_lhu, pid_sh: width = width_half;
      pid_lw, pid_sw:          width = width_word;
      default:                 width = width_none;
    endcase
  end

endmodule

/* design/dispatch_pkg.sv */
// Dispatch definitions for target stations, queue depth and per-station entry formats
package dispatch_pkg;

  typedef enum logic [1:0] {
    station_none,
    station_alu,
    station_ls,
    station_br
  } station_e;

  localparam int queue_depth = 4;

  typedef struct packed {
    rv_isa_pkg::pid_e pid;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [31:0]      imm;
    logic             uses_imm;
    logic             writes;
  } alu_entry_t;

  typedef struct packed {
    rv_isa_pkg::pid_e   pid;
    rv_isa_pkg::width_e width;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [31:0]        imm;
    logic               writes;
  } ls_entry_t;

  typedef struct packed {
    rv_isa_pkg::pid_e pid;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [31:0]      imm;
    logic             writes;
    logic             jumps;
  } br_entry_t;

endpackage

/* design/rv_isa_pkg.sv */
// RV32I instruction set definitions for major opcodes, operation ids and access widths
package rv_isa_pkg;

  localparam logic [6:0] op_load     = 7'b0000011;
  localparam logic [6:0] op_store    = 7'b0100011;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_imm      = 7'b0010011;
  localparam logic [6:0] op_reg      = 7'b0110011;
  localparam logic [6:0] op_lui      = 7'b0110111;
  localparam logic [6:0] op_auipc    = 7'b0010111;
  localparam logic [6:0] op_misc_mem = 7'b0001111;  // FENCE
  localparam logic [6:0] op_system   = 7'b1110011;  // ECALL, EBREAK

  // Zero id so an undecodable word leaves every field clear
  typedef enum logic [5:0] {
    pid_unknown,
    pid_lui,
    pid_auipc,
    pid_jal,
    pid_jalr,
    pid_beq,
    pid_bne,
    pid_blt,
    pid_bge,
    pid_bltu,
    pid_bgeu,
    pid_lb,
    pid_lh,
    pid_lw,
    pid_lbu,
    pid_lhu,
    pid_sb,
    pid_sh,
    pid_sw,
    pid_addi,
    pid_slti,
    pid_sltiu,
    pid_xori,
    pid_ori,
    pid_andi,
    pid_slli,
    pid_srli,
    pid_srai,
    pid_add,
    pid_sub,
    pid_sll,
    pid_slt,
    pid_sltu,
    pid_xor,
    pid_srl,
    pid_sra,
    pid_or,
    pid_and,
    pid_ecall,
    pid_ebreak
  } pid_e;

  // Low bits line up with funct3 of loads and stores
  typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_half = 2'd1,
    width_word = 2'd2,
    width_none = 2'd3
  } width_e;

endpackage
